/* Bender.yml */
package:
  name: cavlc_scan

export_include_dirs:
  - include

sources:
  - files:
      - rtl/cavlc_pkg.sv
      - rtl/cavlc_block_seq.sv
      - rtl/cavlc_scan_ctrl.sv
      - rtl/cavlc_coeff_stats.sv
      - rtl/cavlc_top.sv
  - target: test
    files:
      - tb/cavlc_tb_assert.sv
      - tb/cavlc_tb.sv

/* include/cavlc_defs.svh */
`ifndef CAVLC_DEFS_SVH
`define CAVLC_DEFS_SVH

// coefficient and row geometry
`define CAVLC_COEFF_W     16
`define CAVLC_BLK_COEFFS  16
`define CAVLC_ROW_W       256   // sixteen coefficients per row
`define CAVLC_SCAN_CYCLES 8     // two coefficients per cycle

// residual memory and block numbering
`define CAVLC_ADDR_W      5
`define CAVLC_BLK_IDX_W   5

// memory map of the residual rows
// luma 4x4 or luma AC rows sit at 0..15
`define CAVLC_ADDR_CHROMA_AC 16  // cb AC 16..19, cr AC 20..23
`define CAVLC_ADDR_LUMA_DC   24  // intra16x16 only
`define CAVLC_ADDR_CHROMA_DC 25  // cb DC 25, cr DC 26

`endif

/* list.f */
+incdir+include
rtl/cavlc_pkg.sv
rtl/cavlc_block_seq.sv
rtl/cavlc_scan_ctrl.sv
rtl/cavlc_coeff_stats.sv
rtl/cavlc_top.sv
tb/cavlc_tb_assert.sv
tb/cavlc_tb.sv

/* rtl/cavlc_block_seq.sv */
`timescale 1ns/1ps
`include "cavlc_defs.svh"

module cavlc_block_seq (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     start_i,
	input  cavlc_pkg::mb_info_t      mb_info_i,
	input  logic                     blk_end_i,
	output logic [`CAVLC_ADDR_W-1:0] addr_o,
	output cavlc_pkg::blk_desc_t     desc_o,
	output logic                     scan_run_o,
	output logic                     mb_done_o,
	output logic                     busy_o
);

	typedef struct packed {
		logic                        found;
		logic [`CAVLC_BLK_IDX_W-1:0] idx;
	} srch_t;

	cavlc_pkg::mb_info_t         info_r;
	logic [`CAVLC_BLK_IDX_W-1:0] cur_idx;
	logic                        busy_r;
	logic                        run_r;
	logic                        done_pend;
	logic                        mb_done_r;
	srch_t                       first_blk;
	srch_t                       next_blk;
	cavlc_pkg::blk_kind_e        kind;

	// skip rules of the partition and the coded block pattern
	function automatic logic is_coded(cavlc_pkg::mb_info_t info,
	                                  logic [`CAVLC_BLK_IDX_W-1:0] idx);
		logic chroma_any;
		logic chroma_ac;
		logic coded;
		chroma_any = (info.cbp_chroma != 2'd0);
		chroma_ac  = (info.cbp_chroma == 2'd2);
		if (info.intra16x16) begin
			if (idx == 5'd0)
				coded = 1'b1;            // luma DC always sent
			else if (idx <= 5'd16)
				coded = |info.cbp_luma;  // all AC or none
			else if (idx <= 5'd18)
				coded = chroma_any;
			else if (idx <= 5'd26)
				coded = chroma_ac;
			else
				coded = 1'b0;
		end else begin
			if (idx <= 5'd15)
				coded = info.cbp_luma[idx[3:2]];  // per 8x8 group
			else if (idx <= 5'd17)
				coded = chroma_any;
			else if (idx <= 5'd25)
				coded = chroma_ac;
			else
				coded = 1'b0;
		end
		return coded;
	endfunction

	// lowest coded block index at or above from
	function automatic srch_t find_coded(cavlc_pkg::mb_info_t info,
	                                     logic [`CAVLC_BLK_IDX_W-1:0] from);
		srch_t res;
		res = '0;
		for (int i = 2**`CAVLC_BLK_IDX_W - 1; i >= 0; i--) begin
			if (`CAVLC_BLK_IDX_W'(i) >= from && is_coded(info, `CAVLC_BLK_IDX_W'(i))) begin
				res.found = 1'b1;
				res.idx   = `CAVLC_BLK_IDX_W'(i);
			end
		end
		return res;
	endfunction

	assign first_blk = find_coded(mb_info_i, '0);
	assign next_blk  = find_coded(info_r, cur_idx + 1'b1);

	// block kind and memory address of the current index
	always_comb begin
		kind   = cavlc_pkg::LUMA_4X4;
		addr_o = `CAVLC_ADDR_W'(cur_idx);
		if (info_r.intra16x16) begin
			if (cur_idx == 5'd0) begin
				kind   = cavlc_pkg::LUMA_DC;
				addr_o = `CAVLC_ADDR_W'(`CAVLC_ADDR_LUMA_DC);
			end else if (cur_idx <= 5'd16) begin
				kind   = cavlc_pkg::LUMA_AC;
				addr_o = `CAVLC_ADDR_W'(cur_idx - 5'd1);
			end else if (cur_idx <= 5'd18) begin
				kind   = cavlc_pkg::CHROMA_DC;
				addr_o = `CAVLC_ADDR_W'(`CAVLC_ADDR_CHROMA_DC + (cur_idx - 5'd17));
			end else begin
				kind   = cavlc_pkg::CHROMA_AC;
				addr_o = `CAVLC_ADDR_W'(`CAVLC_ADDR_CHROMA_AC + (cur_idx - 5'd19));
			end
		end else if (cur_idx >= 5'd16) begin
			if (cur_idx <= 5'd17) begin
				kind   = cavlc_pkg::CHROMA_DC;
				addr_o = `CAVLC_ADDR_W'(`CAVLC_ADDR_CHROMA_DC + (cur_idx - 5'd16));
			end else begin
				kind   = cavlc_pkg::CHROMA_AC;
				addr_o = `CAVLC_ADDR_W'(`CAVLC_ADDR_CHROMA_AC + (cur_idx - 5'd18));
			end
		end
	end

	assign desc_o.idx     = cur_idx;
	assign desc_o.kind    = kind;
	assign desc_o.mb_last = !next_blk.found;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			info_r    <= '0;
			cur_idx   <= '0;
			busy_r    <= 1'b0;
			run_r     <= 1'b0;
			done_pend <= 1'b0;
			mb_done_r <= 1'b0;
		end else begin
			mb_done_r <= done_pend;
			done_pend <= 1'b0;
			if (start_i && !busy_r) begin
				info_r    <= mb_info_i;
				cur_idx   <= first_blk.idx;
				busy_r    <= 1'b1;
				run_r     <= first_blk.found;
				done_pend <= !first_blk.found;  // empty MB finishes at once
			end else if (blk_end_i) begin
				if (desc_o.mb_last) begin
					run_r     <= 1'b0;
					done_pend <= 1'b1;
				end else begin
					cur_idx <= next_blk.idx;  // scan next block back to back
				end
			end
			if (mb_done_r)
				busy_r <= 1'b0;  // stays up through the done cycle
		end
	end

	assign scan_run_o = run_r;
	assign mb_done_o  = mb_done_r;
	assign busy_o     = busy_r;

endmodule

/* rtl/cavlc_coeff_stats.sv */
`timescale 1ns/1ps
`include "cavlc_defs.svh"

module cavlc_coeff_stats (
	input  logic                   clk,
	input  logic                   rst_n,
	input  cavlc_pkg::coeff_pair_t pair_i,
	input  logic                   pair_valid_i,
	output logic                   stats_valid_o,
	output cavlc_pkg::blk_stats_t  stats_o
);

	localparam int POS_W = $clog2(`CAVLC_BLK_COEFFS);

	typedef struct packed {
		logic [4:0]       nz_cnt;    // nonzero eligible coefficients
		logic [POS_W-1:0] last_nz;   // highest nonzero position
		logic [1:0]       t1_cnt;    // trailing ones, saturates at 3
		logic [2:0]       t1_signs;
	} acc_t;

	acc_t                  acc_r;
	acc_t                  acc_in;
	acc_t                  acc_mid;
	acc_t                  acc_nxt;
	logic [POS_W-1:0]      pos0;
	logic [POS_W-1:0]      pos1;
	logic                  is_ac;
	logic                  last_phase;
	logic [4:0]            tz_span;
	cavlc_pkg::blk_stats_t stats_nxt;

	function automatic logic eligible(cavlc_pkg::blk_kind_e kind, logic [POS_W-1:0] pos);
		logic ok;
		case (kind)
			cavlc_pkg::LUMA_AC,
			cavlc_pkg::CHROMA_AC: ok = (pos != '0);   // DC slot not coded here
			cavlc_pkg::CHROMA_DC: ok = (pos < 4);     // 2x2 DC
			default:              ok = 1'b1;
		endcase
		return ok;
	endfunction

	// fold one coefficient into the running state
	function automatic acc_t step(acc_t a, logic signed [`CAVLC_COEFF_W-1:0] c,
	                              logic elig, logic [POS_W-1:0] pos);
		acc_t r;
		logic is_one;
		r      = a;
		is_one = (c == 1) || (c == -1);
		if (elig && c != '0) begin
			r.nz_cnt  = a.nz_cnt + 5'd1;
			r.last_nz = pos;
			if (is_one) begin
				r.t1_cnt   = (a.t1_cnt == 2'd3) ? 2'd3 : a.t1_cnt + 2'd1;
				r.t1_signs = {a.t1_signs[1:0], c[`CAVLC_COEFF_W-1]};
			end else begin
				r.t1_cnt   = '0;  // larger level breaks the run
				r.t1_signs = '0;
			end
		end
		return r;
	endfunction

	assign pos0       = {pair_i.phase, 1'b0};
	assign pos1       = {pair_i.phase, 1'b1};
	assign last_phase = (pair_i.phase == ($bits(pair_i.phase))'(`CAVLC_SCAN_CYCLES - 1));
	assign is_ac      = (pair_i.desc.kind == cavlc_pkg::LUMA_AC) ||
	                    (pair_i.desc.kind == cavlc_pkg::CHROMA_AC);

	always_comb begin
		acc_in  = (pair_i.phase == '0) ? '0 : acc_r;  // fresh block
		acc_mid = step(acc_in, pair_i.c0, eligible(pair_i.desc.kind, pos0), pos0);
		acc_nxt = step(acc_mid, pair_i.c1, eligible(pair_i.desc.kind, pos1), pos1);
	end

	// eligible positions up to the last nonzero one
	assign tz_span = {1'b0, acc_nxt.last_nz} + (is_ac ? 5'd0 : 5'd1);

	always_comb begin
		stats_nxt.blk_idx       = pair_i.desc.idx;
		stats_nxt.total_coeff   = acc_nxt.nz_cnt;
		stats_nxt.trailing_ones = acc_nxt.t1_cnt;
		stats_nxt.t1_signs      = acc_nxt.t1_signs;
		if (acc_nxt.nz_cnt == '0)
			stats_nxt.total_zeros = '0;
		else
			stats_nxt.total_zeros = 4'(tz_span - acc_nxt.nz_cnt);
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			acc_r         <= '0;
			stats_valid_o <= 1'b0;
		end else begin
			stats_valid_o <= pair_valid_i && last_phase;
			if (pair_valid_i)
				acc_r <= acc_nxt;
		end
	end

	always_ff @(posedge clk) begin
		if (pair_valid_i && last_phase)
			stats_o <= stats_nxt;
	end

endmodule

/* rtl/cavlc_pkg.sv */
`include "cavlc_defs.svh"

package cavlc_pkg;

	// macroblock descriptor, sampled with start
	typedef struct packed {
		logic       intra16x16;  // 1 = intra16x16 partition
		logic [3:0] cbp_luma;    // one bit per 8x8 luma group
		logic [1:0] cbp_chroma;  // 0 none, 1 DC only, 2 DC and AC
	} mb_info_t;

	typedef enum logic [2:0] {
		LUMA_4X4  = 3'd0,
		LUMA_DC   = 3'd1,
		LUMA_AC   = 3'd2,
		CHROMA_DC = 3'd3,
		CHROMA_AC = 3'd4
	} blk_kind_e;

	// block currently addressed in the residual memory
	typedef struct packed {
		logic [`CAVLC_BLK_IDX_W-1:0] idx;
		blk_kind_e                   kind;
		logic                        mb_last;  // final coded block of the MB
	} blk_desc_t;

	// coefficient pair tagged with its scan phase and block
	typedef struct packed {
		logic signed [`CAVLC_COEFF_W-1:0]         c0;  // scan position 2*phase
		logic signed [`CAVLC_COEFF_W-1:0]         c1;  // scan position 2*phase+1
		logic [$clog2(`CAVLC_SCAN_CYCLES)-1:0]    phase;
		blk_desc_t                                desc;
	} coeff_pair_t;

	// per-block statistics record
	typedef struct packed {
		logic [`CAVLC_BLK_IDX_W-1:0] blk_idx;
		logic [4:0]                  total_coeff;
		logic [1:0]                  trailing_ones;
		logic [2:0]                  t1_signs;     // bit 0 is the highest-frequency one
		logic [3:0]                  total_zeros;
	} blk_stats_t;

endpackage

/* rtl/cavlc_scan_ctrl.sv */
`timescale 1ns/1ps
`include "cavlc_defs.svh"

module cavlc_scan_ctrl (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      scan_run_i,
	input  cavlc_pkg::blk_desc_t      desc_i,
	input  logic [`CAVLC_ROW_W-1:0]   data_i,
	output cavlc_pkg::coeff_pair_t    pair_o,
	output logic                      pair_valid_o,
	output logic                      blk_end_o
);

	logic [$clog2(`CAVLC_SCAN_CYCLES)-1:0] phase;
	cavlc_pkg::coeff_pair_t                pair_nxt;

	// phase counter, wraps on its own at the block boundary
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			phase <= '0;
		end else if (scan_run_i) begin
			phase <= phase + 1'b1;
		end else begin
			phase <= '0;
		end
	end

	assign blk_end_o = scan_run_i && (phase == ($bits(phase))'(`CAVLC_SCAN_CYCLES - 1));

	// coefficients 2p and 2p+1 of the current row
	always_comb begin
		pair_nxt.c0    = data_i[(2 * phase) * `CAVLC_COEFF_W +: `CAVLC_COEFF_W];
		pair_nxt.c1    = data_i[(2 * phase + 1) * `CAVLC_COEFF_W +: `CAVLC_COEFF_W];
		pair_nxt.phase = phase;
		pair_nxt.desc  = desc_i;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pair_valid_o <= 1'b0;
		end else begin
			pair_valid_o <= scan_run_i;
		end
	end

	always_ff @(posedge clk) begin
		if (scan_run_i)
			pair_o <= pair_nxt;  // tagged pair for the stats stage
	end

endmodule

/* rtl/cavlc_top.sv */
`timescale 1ns/1ps
`include "cavlc_defs.svh"

module cavlc_top (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     start_i,
	input  cavlc_pkg::mb_info_t      mb_info_i,
	output logic [`CAVLC_ADDR_W-1:0] addr_o,
	input  logic [`CAVLC_ROW_W-1:0]  data_i,
	output logic                     stats_valid_o,
	output cavlc_pkg::blk_stats_t    stats_o,
	output logic                     mb_done_o,
	output logic                     busy_o
);

	cavlc_pkg::blk_desc_t   desc;
	cavlc_pkg::coeff_pair_t pair;
	logic                   scan_run;
	logic                   blk_end;
	logic                   pair_valid;

	cavlc_block_seq u_block_seq (
		.clk        (clk),
		.rst_n      (rst_n),
		.start_i    (start_i),
		.mb_info_i  (mb_info_i),
		.blk_end_i  (blk_end),
		.addr_o     (addr_o),
		.desc_o     (desc),
		.scan_run_o (scan_run),
		.mb_done_o  (mb_done_o),
		.busy_o     (busy_o)
	);

	cavlc_scan_ctrl u_scan_ctrl (
		.clk          (clk),
		.rst_n        (rst_n),
		.scan_run_i   (scan_run),
		.desc_i       (desc),
		.data_i       (data_i),
		.pair_o       (pair),
		.pair_valid_o (pair_valid),
		.blk_end_o    (blk_end)
	);

	cavlc_coeff_stats u_coeff_stats (
		.clk           (clk),
		.rst_n         (rst_n),
		.pair_i        (pair),
		.pair_valid_i  (pair_valid),
		.stats_valid_o (stats_valid_o),
		.stats_o       (stats_o)
	);

endmodule

/* tb/cavlc_tb.sv */
`timescale 1ns/1ps
`include "cavlc_defs.svh"

module cavlc_tb;

	localparam int     NUM_ROWS    = 14;
	localparam int     MEM_DEPTH   = 27;
	localparam longint WATCHDOG_NS = NUM_ROWS * 230 * 40;

	typedef struct packed {
		cavlc_pkg::mb_info_t info;
		logic [1:0]          fill;        // 0 zero, 1 sparse, 2 +-1 tails, 3 full
		logic                busy_start;  // second start while busy
		logic [4:0]          n_blk;       // coded blocks in the MB
	} row_t;

	logic                     clk;
	logic                     rst_n;
	logic                     start_i;
	cavlc_pkg::mb_info_t      mb_info_i;
	logic [`CAVLC_ADDR_W-1:0] addr_o;
	logic [`CAVLC_ROW_W-1:0]  data_i;
	logic                     stats_valid_o;
	cavlc_pkg::blk_stats_t    stats_o;
	logic                     mb_done_o;
	logic                     busy_o;

	logic [`CAVLC_ROW_W-1:0] mem [MEM_DEPTH];
	row_t                    table_r [NUM_ROWS];
	int                      exp_addr[$];
	cavlc_pkg::blk_stats_t   exp_stats[$];
	int                      errors;
	int unsigned             seed;

	cavlc_top DUT (.*);

	assign data_i = (addr_o < MEM_DEPTH) ? mem[addr_o] : '0;  // combinational read

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired before the last table row finished");
		$display("Test FAILED");
		$finish;
	end

	task automatic load_table();
		// {intra16x16, cbp_luma, cbp_chroma, fill, busy_start, n_blk}
		table_r[0]  = {1'b0, 4'b0000, 2'd0, 2'd0, 1'b0, 5'd0};   // empty MB
		table_r[1]  = {1'b0, 4'b0101, 2'd0, 2'd1, 1'b0, 5'd8};
		table_r[2]  = {1'b0, 4'b1010, 2'd1, 2'd2, 1'b0, 5'd10};
		table_r[3]  = {1'b0, 4'b0011, 2'd2, 2'd3, 1'b0, 5'd18};
		table_r[4]  = {1'b0, 4'b1111, 2'd2, 2'd1, 1'b1, 5'd26};
		table_r[5]  = {1'b0, 4'b0000, 2'd1, 2'd2, 1'b0, 5'd2};
		table_r[6]  = {1'b0, 4'b0000, 2'd2, 2'd3, 1'b0, 5'd10};
		table_r[7]  = {1'b1, 4'b0000, 2'd0, 2'd1, 1'b0, 5'd1};   // luma DC only
		table_r[8]  = {1'b1, 4'b1111, 2'd2, 2'd2, 1'b1, 5'd27};
		table_r[9]  = {1'b1, 4'b0100, 2'd1, 2'd3, 1'b0, 5'd19};
		table_r[10] = {1'b1, 4'b0000, 2'd2, 2'd1, 1'b0, 5'd11};
		table_r[11] = {1'b0, 4'b1111, 2'd0, 2'd2, 1'b0, 5'd16};
		table_r[12] = {1'b1, 4'b1000, 2'd2, 2'd0, 1'b0, 5'd27};
		table_r[13] = {1'b0, 4'b0000, 2'd0, 2'd3, 1'b0, 5'd0};
	endtask

	function automatic logic [15:0] gen_coeff(int style, int a, int p);
		int unsigned r;
		int          v;
		r = $urandom;
		v = 0;
		if (style == 1 && r % 4 == 0)
			v = int'((r >> 4) % 3) + 1;
		else if (style == 2 && p < 6)
			v = int'((r >> 4) % 19) - 9;
		else if (style == 2 && r % 3 != 0)
			v = 1;  // long +-1 runs toward high frequency
		else if (style == 3)
			v = (a * 16 + p) % 5 + 1;
		if (r[8] && v > 0)
			v = -v;
		return v[15:0];
	endfunction

	task automatic fill_memory(int style);
		for (int a = 0; a < MEM_DEPTH; a++)
			for (int p = 0; p < 16; p++)
				mem[a][p * 16 +: 16] = gen_coeff(style, a, p);
	endtask

	// kind 0 all positions, 1 AC without DC slot, 2 chroma DC
	function automatic logic is_eligible(int kind, int p);
		return (kind == 1) ? (p != 0) : (kind == 2) ? (p < 4) : 1'b1;
	endfunction

	function automatic cavlc_pkg::blk_stats_t block_stats(int idx, int addr, int kind);
		cavlc_pkg::blk_stats_t s;
		logic signed [15:0]    c;
		logic                  run_open;
		int                    last;
		s         = '0;
		s.blk_idx = idx[4:0];
		run_open  = 1'b1;
		last      = -1;
		for (int p = 15; p >= 0; p--) begin  // highest frequency first
			c = mem[addr][p * 16 +: 16];
			if (is_eligible(kind, p) && c != 0) begin
				s.total_coeff = s.total_coeff + 1'b1;
				if (last < 0)
					last = p;
				if (c != 1 && c != -1) begin
					run_open = 1'b0;
				end else if (run_open && s.trailing_ones < 3) begin
					s.t1_signs[s.trailing_ones] = c[15];
					s.trailing_ones = s.trailing_ones + 1'b1;
				end
			end
		end
		for (int p = 0; p < last; p++) begin
			c = mem[addr][p * 16 +: 16];
			if (is_eligible(kind, p) && c == 0)
				s.total_zeros = s.total_zeros + 1'b1;
		end
		return s;
	endfunction

	task automatic add_block(int idx, int addr, int kind);
		exp_addr.push_back(addr);
		exp_stats.push_back(block_stats(idx, addr, kind));
	endtask

	task automatic build_expected(cavlc_pkg::mb_info_t info);
		int first;
		exp_addr.delete();
		exp_stats.delete();
		if (info.intra16x16) begin
			add_block(0, 24, 0);
			if (info.cbp_luma != 0)
				for (int b = 1; b <= 16; b++)
					add_block(b, b - 1, 1);
		end else begin
			for (int b = 0; b < 16; b++)
				if (info.cbp_luma[b / 4])
					add_block(b, b, 0);
		end
		first = info.intra16x16 ? 17 : 16;  // first chroma DC index
		if (info.cbp_chroma != 0) begin
			add_block(first, 25, 2);
			add_block(first + 1, 26, 2);
		end
		if (info.cbp_chroma == 2)
			for (int b = 0; b < 8; b++)
				add_block(first + 2 + b, 16 + b, 1);
	endtask

	task automatic run_row(int r);
		row_t row;
		int   n;
		int   done_e;
		int   k;
		row = table_r[r];
		fill_memory(row.fill);
		build_expected(row.info);
		n      = exp_addr.size();
		done_e = (n == 0) ? 1 : 8 * n + 1;
		if (n != row.n_blk) begin
			errors++;
			$display("row %0d: model lists %0d blocks but the table has %0d", r, n, row.n_blk);
		end
		@(negedge clk);
		start_i   = 1'b1;
		mb_info_i = row.info;
		for (int e = 0; e <= done_e + 1; e++) begin
			@(negedge clk);  // cycle after edge e
			start_i   = row.busy_start && e == 3;
			mb_info_i = row.info ^ {7{start_i}};
			k         = (e - 9) / 8;
			if (e < 8 * n && addr_o !== exp_addr[e / 8]) begin
				errors++;
				$display("FAIL %0t: row %0d addr_o %0d, expected %0d",
				         $time, r, addr_o, exp_addr[e / 8]);
			end
			if (e >= 9 && (e - 9) % 8 == 0 && k < n) begin
				if (stats_valid_o !== 1'b1) begin
					errors++;
					$display("row %0d: no stats pulse for block %0d after edge %0d", r, k, e);
				end else if (stats_o !== exp_stats[k]) begin
					errors++;
					$display("FAIL %0t: row %0d block %0d stats %h, expected %h",
					         $time, r, k, stats_o, exp_stats[k]);
				end
			end else if (stats_valid_o !== 1'b0) begin
				errors++;
				$display("row %0d: extra stats pulse after edge %0d", r, e);
			end
			if (mb_done_o !== (e == done_e)) begin
				errors++;
				$display("row %0d: mb_done_o is %b after edge %0d", r, mb_done_o, e);
			end
			if (busy_o !== (e <= done_e)) begin
				errors++;
				$display("FAIL %0t: row %0d busy_o is %b after edge %0d",
				         $time, r, busy_o, e);
			end
		end
	endtask

	initial begin
		seed      = $urandom(32'h3d2a_9e63);
		errors    = 0;
		rst_n     = 1'b0;
		start_i   = 1'b0;
		mb_info_i = '0;
		fill_memory(0);
		load_table();
		repeat (8) @(posedge clk);
		@(negedge clk);
		if (busy_o !== 1'b0 || stats_valid_o !== 1'b0 || mb_done_o !== 1'b0 ||
		    addr_o !== '0) begin
			errors++;
			$display("FAIL %0t: outputs not idle during reset", $time);
		end
		rst_n = 1'b1;
		for (int r = 0; r < NUM_ROWS; r++)
			run_row(r);
		$display("checks: %0d errors, %0d assertion failures", errors, DUT.u_assert.fail_cnt);
		if (errors + DUT.u_assert.fail_cnt == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

/* tb/cavlc_tb_assert.sv */
`timescale 1ns/1ps
`include "cavlc_defs.svh"

module cavlc_tb_assert (
	input logic                     clk,
	input logic                     rst_n,
	input logic [`CAVLC_ADDR_W-1:0] addr_i,
	input logic                     busy_i,
	input logic                     stats_valid_i,
	input cavlc_pkg::blk_stats_t    stats_i,
	input logic                     mb_done_i
);

	int fail_cnt = 0;  // failed assertions so far

	addr_in_map: assert property (@(posedge clk) disable iff (!rst_n)
		busy_i |-> addr_i <= `CAVLC_ADDR_CHROMA_DC + 1)
	else begin
		fail_cnt++;
		$error("read address %0d outside the memory map", addr_i);
	end

	stats_only_busy: assert property (@(posedge clk) disable iff (!rst_n)
		stats_valid_i |-> busy_i)
	else begin
		fail_cnt++;
		$error("stats record while the sequencer is idle");
	end

	t1_within_total: assert property (@(posedge clk) disable iff (!rst_n)
		stats_valid_i |-> stats_i.trailing_ones <= stats_i.total_coeff)
	else begin
		fail_cnt++;
		$error("trailing ones exceed total coefficients");
	end

	done_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
		mb_done_i |=> !mb_done_i)
	else begin
		fail_cnt++;
		$error("mb_done held longer than one cycle");
	end

endmodule

bind cavlc_top cavlc_tb_assert u_assert (
	.clk           (clk),
	.rst_n         (rst_n),
	.addr_i        (addr_o),
	.busy_i        (busy_o),
	.stats_valid_i (stats_valid_o),
	.stats_i       (stats_o),
	.mb_done_i     (mb_done_o)
);
